/* logic/alu.sv */
`timescale 1ns/1ps
`include "rvExec_config.svh"

module alu (
  input  rvExecPkg::wordT  srcA,
  input  rvExecPkg::wordT  srcB,
  input  rvExecPkg::aluOpT op,
  output rvExecPkg::wordT  aluResult,
  output logic             branchCond
);

  import rvExecPkg::*;

  wordT       srcBInv;
  wordT       diff;        // srcA - srcB
  logic       carryOut;    // Set when srcA >= srcB unsigned
  logic       ltSigned;
  logic       ltUnsigned;
  logic [4:0] shamt;

  assign srcBInv = ~srcB;
  assign shamt   = srcB[4:0]; // Upper bits ignored

  fa32 subtractor (
    .a   (srcA),
    .b   (srcBInv),
    .cin (1'b1),
    .sum (diff),
    .cout(carryOut)
  );

  assign ltUnsigned = ~carryOut;

  // Differing signs decide directly, otherwise the difference cannot overflow
  assign ltSigned = (srcA[`XLEN-1] != srcB[`XLEN-1]) ? srcA[`XLEN-1] : diff[`XLEN-1];

  always_comb begin
    aluResult  = '0;
    branchCond = 1'b0;

    if (op.ctrl == ctrlBranch) begin
      aluResult = diff;
      case (op.funct3)
        3'b000:  branchCond = (diff == '0); // BEQ
        3'b001:  branchCond = (diff != '0); // BNE
        3'b100:  branchCond = ltSigned;     // BLT
        3'b101:  branchCond = ~ltSigned;    // BGE
        3'b110:  branchCond = ltUnsigned;   // BLTU
        3'b111:  branchCond = ~ltUnsigned;  // BGEU
        default: branchCond = 1'b0;
      endcase
    end else begin
      case (op.funct3)
        3'b000:  aluResult = op.alt ? diff : srcA + srcB; // SUB or ADD
        3'b001:  aluResult = srcA << shamt;               // SLL
        3'b010:  aluResult = wordT'(ltSigned);            // SLT
        3'b011:  aluResult = wordT'(ltUnsigned);          // SLTU
        3'b100:  aluResult = srcA ^ srcB;
        3'b101: begin
          if (op.alt) begin
            aluResult = wordT'($signed(srcA) >>> shamt); // SRA
          end else begin
            aluResult = srcA >> shamt;                   // SRL
          end
        end
        3'b110:  aluResult = srcA | srcB;
        3'b111:  aluResult = srcA & srcB;
        default: aluResult = '0;
      endcase
    end
  end

  // Subtractor-based compares follow the operand order
  always_comb begin
    if (op.ctrl == ctrlBranch) begin
      assert final ((ltSigned == ($signed(srcA) < $signed(srcB)))
                    && (ltUnsigned == (srcA < srcB)))
        else $error("Branch compare disagrees with the operand order");
    end
  end

endmodule

/* logic/execDecode.sv */
`timescale 1ns/1ps
`include "rvExec_config.svh"

module execDecode (
  input  rvExecPkg::wordT   instr,
  output rvExecPkg::decodeT dec
);

  import rvExecPkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  always_comb begin
    dec = '0;
    case (opcode)
      `OPC_OP: begin
        dec.op.ctrl   = ctrlArith;
        dec.op.funct3 = funct3;
        dec.op.alt    = instr[30]; // SUB and SRA
        dec.regWrite  = 1'b1;
      end
      `OPC_OPIMM: begin
        dec.op.ctrl   = ctrlArith;
        dec.op.funct3 = funct3;
        // Bit 30 is immediate data except in SRAI
        dec.op.alt    = (funct3 == 3'b101) && instr[30];
        dec.useImm    = 1'b1;
        dec.regWrite  = 1'b1;
      end
      `OPC_BRANCH: begin
        dec.op.ctrl   = ctrlBranch;
        dec.op.funct3 = funct3;
        dec.isBranch  = 1'b1;
      end
      default: dec = '0; // Unsupported opcode
    endcase
  end

endmodule

/* logic/fa32.sv */
`timescale 1ns/1ps
`include "rvExec_config.svh"

module fa32 (
  input  rvExecPkg::wordT a,
  input  rvExecPkg::wordT b,
  input  logic            cin,
  output rvExecPkg::wordT sum,
  output logic            cout
);

  localparam int groupWidth = 8;
  localparam int groupCount = `XLEN / groupWidth;

  logic [groupCount:0] carry; // Carry into each group

  assign carry[0] = cin;

  for (genvar g = 0; g < groupCount; g++) begin : gGroup
    logic [groupWidth:0] sumNoCarry; // Group sum for carry-in 0
    logic [groupWidth:0] sumCarry;   // Group sum for carry-in 1

    assign sumNoCarry = {1'b0, a[g*groupWidth +: groupWidth]}
                      + {1'b0, b[g*groupWidth +: groupWidth]};
    assign sumCarry   = {1'b0, a[g*groupWidth +: groupWidth]}
                      + {1'b0, b[g*groupWidth +: groupWidth]} + 1'b1;

    // Incoming carry only picks the precomputed sum
    assign {carry[g+1], sum[g*groupWidth +: groupWidth]} =
      carry[g] ? sumCarry : sumNoCarry;
  end

  assign cout = carry[groupCount];

endmodule

/* logic/immGen.sv */
`timescale 1ns/1ps
`include "rvExec_config.svh"

module immGen (
  input  rvExecPkg::wordT instr,
  output rvExecPkg::wordT immI,
  output rvExecPkg::wordT immB
);

  logic signBit;

  assign signBit = instr[31];

  // I-type imm[11:0] sits in instr[31:20]
  assign immI = {{(`XLEN-12){signBit}}, instr[31:20]};

  // B-type offset is scattered, halfword aligned
  assign immB = {
    {(`XLEN-13){signBit}},
    instr[31],    // imm[12]
    instr[7],     // imm[11]
    instr[30:25], // imm[10:5]
    instr[11:8],  // imm[4:1]
    1'b0
  };

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps
`include "rvExec_config.svh"

module regFile (
  input  logic               clk,
  input  logic               rst,
  input  rvExecPkg::regAddrT rs1Addr,
  input  rvExecPkg::regAddrT rs2Addr,
  output rvExecPkg::wordT    rs1Data,
  output rvExecPkg::wordT    rs2Data,
  input  logic               wrEn,
  input  rvExecPkg::regAddrT wrAddr,
  input  rvExecPkg::wordT    wrData
);

  import rvExecPkg::*;

  wordT regs [`REG_COUNT];

  assign rs1Data = regs[rs1Addr];
  assign rs2Data = regs[rs2Addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin // x0 stays zero
      regs[wrAddr] <= wrData;
    end
  end

  // x0 holds zero from reset on, whatever is written
  assert property (@(posedge clk) disable iff (rst)
    (rs1Addr == '0) |-> (rs1Data == '0))
    else $error("x0 read back nonzero");

endmodule

/* logic/rvExecPkg.sv */
`include "rvExec_config.svh"

package rvExecPkg;

  typedef logic [`XLEN-1:0]              wordT;
  typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;
  typedef logic [1:0]                    aluCtrlT;

  localparam aluCtrlT ctrlArith  = 2'd0; // Register or immediate arithmetic
  localparam aluCtrlT ctrlBranch = 2'd1; // Compare for a conditional branch

  typedef struct packed {
    aluCtrlT    ctrl;
    logic [2:0] funct3;
    logic       alt;      // SUB or SRA
  } aluOpT;

  typedef struct packed {
    aluOpT op;
    logic  useImm;        // B operand from immI
    logic  regWrite;
    logic  isBranch;
  } decodeT;

  typedef struct packed {
    wordT result;
    logic branchTaken;
    wordT branchTarget;
  } execResultT;

endpackage

/* logic/rvExecTop.sv */
`timescale 1ns/1ps

module rvExecTop (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instrValid,
  input  rvExecPkg::wordT       instr,
  input  rvExecPkg::wordT       pc,
  output logic                  resultValid,
  output rvExecPkg::execResultT execOut
);

  import rvExecPkg::*;

  decodeT     dec;
  wordT       immI;
  wordT       immB;
  regAddrT    rs1Addr;
  regAddrT    rs2Addr;
  regAddrT    rdAddr;
  wordT       rs1Data;
  wordT       rs2Data;
  wordT       srcB;
  wordT       aluResult;
  logic       branchCond;
  logic       knownOp;   // Opcode handled by this stage
  logic       wrEn;
  execResultT execNext;

  assign rs1Addr = instr[19:15];
  assign rs2Addr = instr[24:20];
  assign rdAddr  = instr[11:7];

  execDecode decode0 (.instr(instr), .dec(dec));

  immGen imm0 (.instr(instr), .immI(immI), .immB(immB));

  regFile regs0 (
    .clk    (clk),
    .rst    (rst),
    .rs1Addr(rs1Addr),
    .rs2Addr(rs2Addr),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .wrEn   (wrEn),
    .wrAddr (rdAddr),
    .wrData (aluResult)
  );

  assign srcB = dec.useImm ? immI : rs2Data;

  alu alu0 (
    .srcA      (rs1Data),
    .srcB      (srcB),
    .op        (dec.op),
    .aluResult (aluResult),
    .branchCond(branchCond)
  );

  assign knownOp = dec.regWrite | dec.isBranch;
  assign wrEn    = instrValid && dec.regWrite && (rdAddr != '0);

  always_comb begin
    execNext.result       = knownOp ? aluResult : '0; // Zero for unsupported opcodes
    execNext.branchTaken  = branchCond & dec.isBranch;
    execNext.branchTarget = pc + immB;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resultValid <= 1'b0;
      execOut     <= '0;
    end else begin
      resultValid <= instrValid; // One-cycle strobe
      if (instrValid) begin
        execOut <= execNext;
      end
    end
  end

  // Carry-select difference of a branch equals rs1 minus rs2
  assert property (@(posedge clk) disable iff (rst)
    (instrValid && dec.isBranch) |-> (aluResult == rs1Data - rs2Data))
    else $error("Branch difference disagrees with rs1 minus rs2");

endmodule

/* logic/rvExec_config.svh */
`ifndef RVEXEC_CONFIG_SVH
`define RVEXEC_CONFIG_SVH

// Datapath width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// Opcodes handled by the execute stage
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_BRANCH 7'b1100011

`endif

/* rvExec.f */
+incdir+logic
logic/rvExecPkg.sv
logic/fa32.sv
logic/alu.sv
logic/regFile.sv
logic/immGen.sv
logic/execDecode.sv
logic/rvExecTop.sv
tests/rvExecTb.sv

/* tests/rvExecTb.sv */
`timescale 1ns/1ps
`include "rvExec_config.svh"

module rvExecTb;

  import rvExecPkg::*;

  localparam time clkPeriod  = 40ns;
  localparam time driveDelay = 2ns;
  localparam time checkDelay = 1ns; // Outputs settled after the edge

  typedef struct packed {
    wordT instr;
    wordT pc;
    wordT result;
    logic taken;
    wordT target;
  } stimT;

  logic       clk;
  logic       rst;
  logic       instrValid;
  wordT       instr;
  wordT       pc;
  logic       resultValid;
  execResultT execOut;

  stimT  entries[$];
  string tags[$];
  int    numTests;
  int    passCount;
  int    failCount;
  int    errCount;  // Errors inside the current test
  bit    loaded;

  rvExecTop dut0 (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .pc         (pc),
    .resultValid(resultValid),
    .execOut    (execOut)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      errCount++;
    end
  endtask

  task automatic loadStimulus();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] f0, f1, f2, f3, f4;
    fd = $fopen("tests/rvExec_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tests/rvExec_stim.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%s %h %h %h %h %h", tag, f0, f1, f2, f3, f4);
      if (n == 6 && tag.getc(0) != "#") begin // Skip comments and blank lines
        tags.push_back(tag);
        entries.push_back('{f0, f1, f2, f3[0], f4});
      end
    end
    $fclose(fd);
  endtask

  task automatic applyEntry(input int i);
    instr      = entries[i].instr;
    pc         = entries[i].pc;
    instrValid = 1'b1;
  endtask

  task automatic checkEntry(input int i);
    errCount = 0;
    if (resultValid !== 1'b1) begin
      $display("Test %s: resultValid not high one cycle after the instruction", tags[i]);
      errCount++;
    end
    checkValue("execOut.result", execOut.result, entries[i].result);
    checkValue("execOut.branchTaken", execOut.branchTaken, entries[i].taken);
    // Target has a meaning only for branches
    if (entries[i].instr[6:0] == `OPC_BRANCH) begin
      checkValue("execOut.branchTarget", execOut.branchTarget, entries[i].target);
    end
    if (errCount == 0) begin
      passCount++;
      $display("PASS %s", tags[i]);
    end else begin
      failCount++;
      $display("FAIL %s", tags[i]);
    end
  endtask

  initial begin
    wait (loaded);
    #((numTests + 10) * 4 * clkPeriod);
    $display("Run timed out after %0d tests of %0d", passCount + failCount, numTests);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    pc         = '0;
    passCount  = 0;
    failCount  = 0;
    loadStimulus();
    numTests = entries.size();
    loaded   = 1'b1;
    if (numTests == 0) begin
      $display("No stimulus lines were read");
      failCount++;
    end
    repeat (4) @(posedge clk);
    #driveDelay rst = 1'b0;
    errCount = 0;
    checkValue("resultValid", resultValid, 1'b0);
    checkValue("execOut.result", execOut.result, '0);
    checkValue("execOut.branchTaken", execOut.branchTaken, 1'b0);
    checkValue("execOut.branchTarget", execOut.branchTarget, '0);
    if (errCount == 0) begin
      passCount++;
      $display("PASS reset");
    end else begin
      failCount++;
      $display("FAIL reset");
    end
    if (numTests > 0) begin
      @(posedge clk);
      #driveDelay applyEntry(0);
      for (int i = 0; i < numTests; i++) begin
        @(posedge clk);
        #checkDelay checkEntry(i);
        #(driveDelay - checkDelay);
        if (i + 1 < numTests) begin
          applyEntry(i + 1); // Back-to-back issue
        end else begin
          instrValid = 1'b0;
        end
      end
    end
    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tests/rvExec_stim.txt */
# tag instr pc result taken target, all hex after the tag
# target is the expected pc plus B immediate, compared on branch lines only
addiPos      00500093 00000000 00000005 0 00000000
addiNeg      FFD00113 00000004 FFFFFFFD 0 00000000
addiBit30Neg C0000193 00000008 FFFFFC00 0 00000000
addiBit30Pos 7FF08213 0000000C 00000804 0 00000000
xori         0F014293 00000010 FFFFFF0D 0 00000000
ori          1000E313 00000014 00000105 0 00000000
andi         0FF17393 00000018 000000FD 0 00000000
slti         00112413 0000001C 00000001 0 00000000
sltiu        00113493 00000020 00000000 0 00000000
add          00208533 00000024 00000002 0 00000000
sub          402085B3 00000028 00000008 0 00000000
and          00627633 0000002C 00000004 0 00000000
or           006266B3 00000030 00000905 0 00000000
xor          00624733 00000034 00000901 0 00000000
slt          001127B3 00000038 00000001 0 00000000
sltu         00113833 0000003C 00000000 0 00000000
loadShamt33  02100893 00000040 00000021 0 00000000
sll          01119933 00000044 FFFFF800 0 00000000
srl          0111D9B3 00000048 7FFFFE00 0 00000000
sra          4111DA33 0000004C FFFFFE00 0 00000000
slli         00419A93 00000050 FFFFC000 0 00000000
srli         0081DB13 00000054 00FFFFFC 0 00000000
srai         4081DB93 00000058 FFFFFFFC 0 00000000
writeX0      00708013 0000005C 0000000C 0 00000000
readX0       00000C33 00000060 00000000 0 00000000
loadX25      06400C93 00000064 00000064 0 00000000
dependAdd    019C8D33 00000068 000000C8 0 00000000
beqTaken     00108863 00000100 00000000 1 00000110
beqNot       FE208CE3 00000104 00000008 0 000000FC
bneTaken     00209863 00000108 00000008 1 00000118
bneNot       FE211CE3 0000010C 00000000 0 00000104
bltTaken     00114863 00000110 FFFFFFF8 1 00000120
bltNot       FE20CCE3 00000114 00000008 0 0000010C
bgeEqual     0010D863 00000118 00000000 1 00000128
bgeNot       FE115CE3 0000011C FFFFFFF8 0 00000114
bltuTaken    0020E863 00000120 00000008 1 00000130
bltuNot      FE116CE3 00000124 FFFFFFF8 0 0000011C
bgeuTaken    00117863 00000128 FFFFFFF8 1 00000138
bgeuNot      FE20FCE3 0000012C 00000008 0 00000124
readX25      000C8D93 00000130 00000064 0 00000000
loadWord     00002083 00000134 00000000 0 00000000
readX1       00008E13 00000138 00000005 0 00000000
